/* hw/immu_consts.svh */
// Instruction MMU constants
`ifndef IMMU_CONSTS_SVH
`define IMMU_CONSTS_SVH

// Virtual and physical address width
`define IMMU_AW 32

// MSR and TLB word width
`define IMMU_DW 32

// Log2 of the page size
`define IMMU_PAGE_SHIFT 12

// Log2 of the number of TLB sets
`define IMMU_TLB_SET_BITS 6

// MSR address width
`define IMMU_MSR_AW 12

// MSR map
`define IMMU_MSR_PSR 12'h000
`define IMMU_MSR_IMMID 12'h004
// TLB windows, each aligned to the set count
`define IMMU_MSR_TLBL_BASE 12'h200
`define IMMU_MSR_TLBH_BASE 12'h280

`endif

/* hw/immu_pkg.sv */
// Instruction MMU types
`default_nettype none

`include "immu_consts.svh"

package immu_pkg;

   // Page numbers
   typedef logic [`IMMU_AW-`IMMU_PAGE_SHIFT-1:0] vpn_t;
   typedef logic [`IMMU_AW-`IMMU_PAGE_SHIFT-1:0] ppn_t;

   // TLB set index
   typedef logic [`IMMU_TLB_SET_BITS-1:0] tlb_idx_t;

   // MSR bus fields
   typedef logic [`IMMU_MSR_AW-1:0] msr_addr_t;
   typedef logic [`IMMU_DW-1:0] msr_data_t;

   // Lower TLB half, tag and valid
   typedef struct packed {
      vpn_t vpn;
      logic [10:0] rsvd;
      logic v;
   } tlb_lo_t;

   // Higher TLB half, PPN and permissions
   typedef struct packed {
      ppn_t ppn;
      logic [2:0] rsvd_hi;
      logic s;
      logic [2:0] rsvd_mid;
      logic rx;
      logic ux;
      logic [1:0] rsvd_lo;
      logic p;
   } tlb_hi_t;

   // Fetch side request and response
   typedef struct packed {
      vpn_t vpn;
   } xlate_req_t;

   typedef struct packed {
      ppn_t ppn;
      logic itlb_miss;
      logic page_fault;
   } xlate_rsp_t;

   // One MSR write
   typedef struct packed {
      msr_addr_t addr;
      msr_data_t data;
   } msr_wr_t;

   // PSR bits seen by the MMU, imme in bit 0
   typedef struct packed {
      logic rm;
      logic imme;
   } psr_t;

   // Write to one TLB half
   typedef struct packed {
      tlb_idx_t idx;
      msr_data_t data;
   } tlb_wr_t;

endpackage

`default_nettype wire

/* hw/tlb_ram.sv */
// TLB register file
`default_nettype none

module tlb_ram
#(
   parameter int data_width = 32,
   parameter int addr_width = 6
)
(
   input  logic                  clk,
   // Read port
   input  logic                  re,
   input  logic [addr_width-1:0] raddr,
   output logic [data_width-1:0] rdata,
   // Write port
   input  logic                  we,
   input  logic [addr_width-1:0] waddr,
   input  logic [data_width-1:0] wdata
);

   // Storage array
   logic [data_width-1:0] mem [2**addr_width];

   // Write at the edge
   always_ff @(posedge clk)
   begin
      if (we)
         mem[waddr] <= wdata;
   end

   // Registered read
   // Same edge write is not seen until the next read
   always_ff @(posedge clk)
   begin
      if (re)
         rdata <= mem[raddr];
   end

   // Read data holds while re is low

   // Write control must be known
   a_we_known: assert property (
      @(posedge clk) !$isunknown(we)
   ) else $error("tlb_ram we is unknown");

   // Write address must be known when writing
   a_waddr_known: assert property (
      @(posedge clk) we |-> !$isunknown(waddr)
   ) else $error("tlb_ram waddr is unknown during write");

endmodule

`default_nettype wire

/* hw/immu_msr_port.sv */
// Instruction MMU MSR port
`default_nettype none

`include "immu_consts.svh"

module immu_msr_port
(
   input  logic                clk,
   input  logic                reset,
   // MSR write bus
   input  logic                msr_we,
   input  immu_pkg::msr_wr_t   msr_wr,
   // MSR read port
   input  immu_pkg::msr_addr_t msr_raddr,
   output immu_pkg::msr_data_t msr_rdata,
   // PSR bits toward the MMU
   output immu_pkg::psr_t      psr,
   // Lower TLB half write
   output logic                tlbl_we,
   output immu_pkg::tlb_wr_t   tlbl_wr,
   // Higher TLB half write
   output logic                tlbh_we,
   output immu_pkg::tlb_wr_t   tlbh_wr
);

   // Write address with the entry bits cleared
   immu_pkg::msr_addr_t win_base;
   // Decoded write targets
   logic psr_hit;
   logic tlbl_hit;
   logic tlbh_hit;

   assign win_base = {msr_wr.addr[`IMMU_MSR_AW-1:`IMMU_TLB_SET_BITS],
                      {`IMMU_TLB_SET_BITS{1'b0}}};

   // PSR is one address
   assign psr_hit = msr_we && (msr_wr.addr == `IMMU_MSR_PSR);

   // TLB windows cover one entry per set
   assign tlbl_hit = msr_we && (win_base == `IMMU_MSR_TLBL_BASE);
   assign tlbh_hit = msr_we && (win_base == `IMMU_MSR_TLBH_BASE);

   // PSR register
   // Cleared on reset so translation starts off
   always_ff @(posedge clk)
   begin
      if (reset)
         psr <= '0;
      else if (psr_hit)
         psr <= immu_pkg::psr_t'(msr_wr.data[1:0]);
   end

   // TLB writes go straight through
   // The RAM takes them at the same edge
   assign tlbl_we = tlbl_hit;
   assign tlbh_we = tlbh_hit;

   // Entry index from the low address bits
   assign tlbl_wr.idx = msr_wr.addr[`IMMU_TLB_SET_BITS-1:0];
   assign tlbh_wr.idx = msr_wr.addr[`IMMU_TLB_SET_BITS-1:0];

   // Both halves share the write data
   assign tlbl_wr.data = msr_wr.data;
   assign tlbh_wr.data = msr_wr.data;

   // Read mux
   always_comb
   begin
      msr_rdata = '0;
      case (msr_raddr)
         `IMMU_MSR_PSR:
         begin
            msr_rdata[1:0] = psr;
         end
         `IMMU_MSR_IMMID:
         begin
            // Log2 of the set count
            msr_rdata = immu_pkg::msr_data_t'(`IMMU_TLB_SET_BITS);
         end
         default:
         begin
            msr_rdata = '0;
         end
      endcase
   end

   // Write strobe must be known
   a_msr_we_known: assert property (
      @(posedge clk) disable iff (reset)
      !$isunknown(msr_we)
   ) else $error("msr_we is unknown");

   // Write address must be known when writing
   a_msr_addr_known: assert property (
      @(posedge clk) disable iff (reset)
      msr_we |-> !$isunknown(msr_wr.addr)
   ) else $error("msr_wr.addr is unknown during write");

endmodule

`default_nettype wire

/* hw/immu.sv */
// Instruction translation core
`default_nettype none

`include "immu_consts.svh"

module immu
(
   input  logic                 clk,
   input  logic                 reset,
   // Fetch request
   input  logic                 req_valid,
   input  immu_pkg::xlate_req_t req,
   // PSR bits
   input  immu_pkg::psr_t       psr,
   // TLB fill from the MSR port
   input  logic                 tlbl_we,
   input  immu_pkg::tlb_wr_t    tlbl_wr,
   input  logic                 tlbh_we,
   input  immu_pkg::tlb_wr_t    tlbh_wr,
   // Fetch response
   output logic                 rsp_valid,
   output immu_pkg::xlate_rsp_t rsp
);

   // Set index of the incoming request
   immu_pkg::tlb_idx_t req_idx;
   // Request state held for the response cycle
   immu_pkg::vpn_t     vpn_q;
   immu_pkg::psr_t     psr_q;
   // Entry read from both halves
   immu_pkg::tlb_lo_t  tlb_lo;
   immu_pkg::tlb_hi_t  tlb_hi;
   // Lookup results
   logic               tag_hit;
   logic               perm_denied;

   // Direct mapped by the low VPN bits
   assign req_idx = req.vpn[`IMMU_TLB_SET_BITS-1:0];

   // Response strobe and PSR snapshot
   always_ff @(posedge clk)
   begin
      if (reset)
      begin
         rsp_valid <= 1'b0;
         psr_q <= '0;
      end
      else
      begin
         rsp_valid <= req_valid;
         if (req_valid)
            psr_q <= psr;
      end
   end

   // VPN of the pending lookup
   always_ff @(posedge clk)
   begin
      if (req_valid)
         vpn_q <= req.vpn;
   end

   // Lower half with valid and tag
   tlb_ram
   #(
      .data_width (`IMMU_DW),
      .addr_width (`IMMU_TLB_SET_BITS)
   )
   u_tlb_lo
   (
      .clk   (clk),
      .re    (req_valid),
      .raddr (req_idx),
      .rdata (tlb_lo),
      .we    (tlbl_we),
      .waddr (tlbl_wr.idx),
      .wdata (tlbl_wr.data)
   );

   // Higher half with PPN and permissions
   tlb_ram
   #(
      .data_width (`IMMU_DW),
      .addr_width (`IMMU_TLB_SET_BITS)
   )
   u_tlb_hi
   (
      .clk   (clk),
      .re    (req_valid),
      .raddr (req_idx),
      .rdata (tlb_hi),
      .we    (tlbh_we),
      .waddr (tlbh_wr.idx),
      .wdata (tlbh_wr.data)
   );

   // Full VPN kept as the tag
   assign tag_hit = tlb_lo.v && (tlb_lo.vpn == vpn_q);

   // Root mode needs rx and user mode needs ux
   assign perm_denied = (psr_q.rm & ~tlb_hi.rx) | (~psr_q.rm & ~tlb_hi.ux);

   // Flags only with translation on
   assign rsp.itlb_miss = psr_q.imme & ~tag_hit;
   assign rsp.page_fault = psr_q.imme & tag_hit & perm_denied;

   // Identity mapping when translation is off
   assign rsp.ppn = psr_q.imme ? tlb_hi.ppn : vpn_q;

   // Request strobe must be known
   a_req_valid_known: assert property (
      @(posedge clk) disable iff (reset)
      !$isunknown(req_valid)
   ) else $error("req_valid is unknown");

   // Looked up VPN must be known
   a_req_known: assert property (
      @(posedge clk) disable iff (reset)
      req_valid |-> !$isunknown(req)
   ) else $error("req is unknown while req_valid is high");

endmodule

`default_nettype wire

/* hw/ifetch_xlate.sv */
// Instruction fetch translation top
`default_nettype none

module ifetch_xlate
(
   input  logic                 clk,
   input  logic                 reset,
   // Fetch request and response
   input  logic                 req_valid,
   input  immu_pkg::xlate_req_t req,
   output logic                 rsp_valid,
   output immu_pkg::xlate_rsp_t rsp,
   // MSR bus
   input  logic                 msr_we,
   input  immu_pkg::msr_wr_t    msr_wr,
   input  immu_pkg::msr_addr_t  msr_raddr,
   output immu_pkg::msr_data_t  msr_rdata
);

   // PSR bits to the core
   immu_pkg::psr_t    psr;
   // TLB fill paths
   logic              tlbl_we;
   immu_pkg::tlb_wr_t tlbl_wr;
   logic              tlbh_we;
   immu_pkg::tlb_wr_t tlbh_wr;

   // MSR decode and PSR
   immu_msr_port u_msr
   (
      .clk       (clk),
      .reset     (reset),
      .msr_we    (msr_we),
      .msr_wr    (msr_wr),
      .msr_raddr (msr_raddr),
      .msr_rdata (msr_rdata),
      .psr       (psr),
      .tlbl_we   (tlbl_we),
      .tlbl_wr   (tlbl_wr),
      .tlbh_we   (tlbh_we),
      .tlbh_wr   (tlbh_wr)
   );

   // Lookup core
   immu u_immu
   (
      .clk       (clk),
      .reset     (reset),
      .req_valid (req_valid),
      .req       (req),
      .psr       (psr),
      .tlbl_we   (tlbl_we),
      .tlbl_wr   (tlbl_wr),
      .tlbh_we   (tlbh_we),
      .tlbh_wr   (tlbh_wr),
      .rsp_valid (rsp_valid),
      .rsp       (rsp)
   );

endmodule

`default_nettype wire

/* testbench/xlate_checker.sv */
// Translation response checker
`default_nettype none

`include "immu_consts.svh"

module xlate_checker
(
   input  logic                 clk,
   input  logic                 reset,
   // Fetch side
   input  logic                 req_valid,
   input  immu_pkg::xlate_req_t req,
   input  logic                 rsp_valid,
   input  immu_pkg::xlate_rsp_t rsp,
   // MSR bus
   input  logic                 msr_we,
   input  immu_pkg::msr_wr_t    msr_wr,
   input  immu_pkg::msr_addr_t  msr_raddr,
   input  immu_pkg::msr_data_t  msr_rdata,
   // Counts for the closing line
   output int                   value_errors,
   output int                   protocol_errors,
   output int                   rsp_checked
);
   timeunit 1ns;
   timeprecision 1ps;

   localparam int num_sets = 1 << `IMMU_TLB_SET_BITS;
   // Entry bit positions
   localparam int v_bit = 0;
   localparam int ux_bit = 3;
   localparam int rx_bit = 4;

   // Request with the shadow state of its edge
   typedef struct packed {
      immu_pkg::vpn_t      vpn;
      logic                imme;
      logic                rm;
      immu_pkg::msr_data_t lo;
      immu_pkg::msr_data_t hi;
   } pending_t;

   // Shadow TLB and PSR
   immu_pkg::msr_data_t shadow_lo [num_sets];
   immu_pkg::msr_data_t shadow_hi [num_sets];
   logic                shadow_imme;
   logic                shadow_rm;
   pending_t            pending_q [$];

   initial
   begin
      value_errors = 0;
      protocol_errors = 0;
      rsp_checked = 0;
   end

   // Response rule
   function automatic immu_pkg::xlate_rsp_t expected_rsp(input pending_t p);
      immu_pkg::xlate_rsp_t r;
      logic hit;
      logic deny;
      if (!p.imme)
      begin
         r.ppn = p.vpn;
         r.itlb_miss = 1'b0;
         r.page_fault = 1'b0;
      end
      else
      begin
         hit = p.lo[v_bit] && (p.lo[31:`IMMU_PAGE_SHIFT] == p.vpn);
         // Root mode needs rx, user mode ux
         deny = p.rm ? !p.hi[rx_bit] : !p.hi[ux_bit];
         r.ppn = p.hi[31:`IMMU_PAGE_SHIFT];
         r.itlb_miss = !hit;
         r.page_fault = hit && deny;
      end
      return r;
   endfunction

   // MSR read map
   function automatic immu_pkg::msr_data_t expected_rdata(input immu_pkg::msr_addr_t addr,
                                                          input logic imme, input logic rm);
      if (addr == `IMMU_MSR_PSR)
         return {30'b0, rm, imme};
      else if (addr == `IMMU_MSR_IMMID)
         return `IMMU_TLB_SET_BITS;
      return '0;
   endfunction

   task automatic compare_rsp(input pending_t p);
      immu_pkg::xlate_rsp_t exp;
      exp = expected_rsp(p);
      rsp_checked++;
      if (rsp.ppn !== exp.ppn)
      begin
         $display("error: rsp.ppn expected %h got %h (vpn %h)", exp.ppn, rsp.ppn, p.vpn);
         value_errors++;
      end
      if (rsp.itlb_miss !== exp.itlb_miss)
      begin
         $display("error: rsp.itlb_miss expected %h got %h (vpn %h)",
                  exp.itlb_miss, rsp.itlb_miss, p.vpn);
         value_errors++;
      end
      if (rsp.page_fault !== exp.page_fault)
      begin
         $display("error: rsp.page_fault expected %h got %h (vpn %h)",
                  exp.page_fault, rsp.page_fault, p.vpn);
         value_errors++;
      end
   endtask

   // Values sampled at the edge are the ones of the cycle before
   always @(posedge clk)
   begin : monitor
      pending_t            p;
      immu_pkg::tlb_idx_t  idx;
      immu_pkg::msr_addr_t win;
      immu_pkg::msr_data_t exp_rdata;
      if (reset)
      begin
         shadow_imme = 1'b0;
         shadow_rm = 1'b0;
         pending_q.delete();
      end
      else
      begin
         // Response to the previous edge's request
         if (rsp_valid === 1'b1)
         begin
            if (pending_q.size() == 0)
            begin
               $display("rsp_valid went high with no request pending at %0t", $time);
               protocol_errors++;
            end
            else
               compare_rsp(pending_q.pop_front());
         end
         else if (rsp_valid !== 1'b0)
         begin
            $display("rsp_valid is unknown at %0t", $time);
            protocol_errors++;
            pending_q.delete();
         end
         else if (pending_q.size() != 0)
         begin
            $display("request for vpn %h got no response at %0t", pending_q[0].vpn, $time);
            protocol_errors++;
            pending_q.delete();
         end
         // Read port against the shadow PSR
         exp_rdata = expected_rdata(msr_raddr, shadow_imme, shadow_rm);
         if (msr_rdata !== exp_rdata)
         begin
            $display("error: msr_rdata at %h expected %h got %h", msr_raddr, exp_rdata, msr_rdata);
            value_errors++;
         end
         // New lookup sees the state before this edge's write
         if (req_valid)
         begin
            idx = req.vpn[`IMMU_TLB_SET_BITS-1:0];
            p.vpn = req.vpn;
            p.imme = shadow_imme;
            p.rm = shadow_rm;
            p.lo = shadow_lo[idx];
            p.hi = shadow_hi[idx];
            pending_q.push_back(p);
         end
         // Mirror MSR writes
         if (msr_we)
         begin
            idx = msr_wr.addr[`IMMU_TLB_SET_BITS-1:0];
            win = {msr_wr.addr[`IMMU_MSR_AW-1:`IMMU_TLB_SET_BITS], {`IMMU_TLB_SET_BITS{1'b0}}};
            if (msr_wr.addr == `IMMU_MSR_PSR)
            begin
               shadow_imme = msr_wr.data[0];
               shadow_rm = msr_wr.data[1];
            end
            else if (win == `IMMU_MSR_TLBL_BASE)
               shadow_lo[idx] = msr_wr.data;
            else if (win == `IMMU_MSR_TLBH_BASE)
               shadow_hi[idx] = msr_wr.data;
         end
      end
   end

endmodule

`default_nettype wire

/* testbench/tb_ifetch_xlate.sv */
// Instruction fetch translation testbench
`default_nettype none

`include "immu_consts.svh"

module tb_ifetch_xlate;
   timeunit 1ns;
   timeprecision 1ps;

   localparam int clk_period = 40;
   localparam int reset_cycles = 16;
   localparam int num_sets = 1 << `IMMU_TLB_SET_BITS;
   localparam int num_random = 64;
   // Directed requests, PSR writes, reads and idle cycles
   localparam int directed_ops = 120;
   // Two MSR writes per TLB set
   localparam int planned_ops = reset_cycles + 2 * num_sets + num_random + directed_ops;
   localparam int timeout_ns = planned_ops * clk_period + 4000;

   // DUT ports
   logic                 clk;
   logic                 reset;
   logic                 req_valid;
   immu_pkg::xlate_req_t req;
   logic                 rsp_valid;
   immu_pkg::xlate_rsp_t rsp;
   logic                 msr_we;
   immu_pkg::msr_wr_t    msr_wr;
   immu_pkg::msr_addr_t  msr_raddr;
   immu_pkg::msr_data_t  msr_rdata;

   // Checker counts
   int value_errors;
   int protocol_errors;
   int rsp_checked;

   // What the stimulus put in each set
   immu_pkg::vpn_t prog_vpn [num_sets];
   logic           prog_v [num_sets];
   int             req_count;

   // LCG state
   int unsigned rng_state = 69405;

   ifetch_xlate uut
   (
      .clk       (clk),
      .reset     (reset),
      .req_valid (req_valid),
      .req       (req),
      .rsp_valid (rsp_valid),
      .rsp       (rsp),
      .msr_we    (msr_we),
      .msr_wr    (msr_wr),
      .msr_raddr (msr_raddr),
      .msr_rdata (msr_rdata)
   );

   xlate_checker u_checker
   (
      .clk             (clk),
      .reset           (reset),
      .req_valid       (req_valid),
      .req             (req),
      .rsp_valid       (rsp_valid),
      .rsp             (rsp),
      .msr_we          (msr_we),
      .msr_wr          (msr_wr),
      .msr_raddr       (msr_raddr),
      .msr_rdata       (msr_rdata),
      .value_errors    (value_errors),
      .protocol_errors (protocol_errors),
      .rsp_checked     (rsp_checked)
   );

   // Free running clock
   initial
   begin
      clk = 1'b0;
      forever #(clk_period / 2) clk = ~clk;
   end

   function automatic int unsigned next_rand();
      rng_state = rng_state * 32'd1664525 + 32'd1013904223;
      return rng_state;
   endfunction

   // One bus cycle, driven just after the edge
   task automatic drive_cycle(input logic rv, input immu_pkg::vpn_t vpn, input logic we,
                              input immu_pkg::msr_addr_t addr, input immu_pkg::msr_data_t data);
      @(posedge clk);
      #2;
      req_valid = rv;
      req.vpn = vpn;
      msr_we = we;
      msr_wr.addr = addr;
      msr_wr.data = data;
      if (rv)
         req_count++;
   endtask

   task automatic send_request(input immu_pkg::vpn_t vpn);
      drive_cycle(1'b1, vpn, 1'b0, '0, '0);
   endtask

   task automatic write_msr(input immu_pkg::msr_addr_t addr, input immu_pkg::msr_data_t data);
      drive_cycle(1'b0, '0, 1'b1, addr, data);
   endtask

   task automatic idle(input int n);
      repeat (n) drive_cycle(1'b0, '0, 1'b0, '0, '0);
   endtask

   // Read port is combinational, checked at the next edge
   task automatic set_read_addr(input immu_pkg::msr_addr_t addr);
      drive_cycle(1'b0, '0, 1'b0, '0, '0);
      msr_raddr = addr;
   endtask

   // Fill both halves of one set, s and p random
   task automatic program_entry(input int idx, input immu_pkg::vpn_t vpn, input logic v,
                                input logic rx, input logic ux);
      immu_pkg::msr_data_t lo;
      immu_pkg::msr_data_t hi;
      int unsigned r;
      r = next_rand();
      lo = {vpn, 11'b0, v};
      hi = {r[31:12], 3'b0, r[3], 3'b0, rx, ux, 2'b0, r[2]};
      write_msr(immu_pkg::msr_addr_t'(`IMMU_MSR_TLBL_BASE + idx), lo);
      write_msr(immu_pkg::msr_addr_t'(`IMMU_MSR_TLBH_BASE + idx), hi);
      prog_vpn[idx] = vpn;
      prog_v[idx] = v;
   endtask

   // Stimulus
   initial
   begin
      immu_pkg::vpn_t vpn;
      immu_pkg::vpn_t new_vpn;
      int unsigned r;
      int idx;
      int other_errors;
      other_errors = 0;
      reset = 1'b1;
      req_valid = 1'b0;
      req = '0;
      msr_we = 1'b0;
      msr_wr = '0;
      msr_raddr = `IMMU_MSR_PSR;
      req_count = 0;
      repeat (reset_cycles) @(posedge clk);
      #2;
      reset = 1'b0;
      // Quiet after reset
      idle(4);
      // Translation off, identity mapping
      for (int i = 0; i < 8; i++)
      begin
         r = next_rand();
         send_request(immu_pkg::vpn_t'(r >> 12));
      end
      idle(2);
      // Fill every set, low half clean, 32..35 cover the permission pairs
      for (int i = 0; i < num_sets; i++)
      begin
         r = next_rand();
         vpn = {r[31:18], immu_pkg::tlb_idx_t'(i)};
         if (i < 32)
            program_entry(i, vpn, (i % 8) != 7, 1'b1, 1'b1);
         else if (i < 36)
            program_entry(i, vpn, 1'b1, ((i - 32) & 2) != 0, ((i - 32) & 1) != 0);
         else
            program_entry(i, vpn, r[0] | r[1], r[2], r[3]);
      end
      // Translation on, user mode
      write_msr(`IMMU_MSR_PSR, 32'h1);
      set_read_addr(`IMMU_MSR_IMMID);
      set_read_addr(`IMMU_MSR_PSR);
      // Back to back hits
      for (int i = 0; i < 32; i++)
         if (prog_v[i])
            send_request(prog_vpn[i]);
      // Invalid entries
      for (int i = 0; i < num_sets; i++)
         if (!prog_v[i])
            send_request(prog_vpn[i]);
      // Tag mismatch at the same index
      for (int i = 0; i < 8; i++)
         send_request(prog_vpn[i] ^ 20'h80000);
      idle(1);
      // Each rx and ux pair in user then root mode
      for (int mode = 0; mode < 2; mode++)
      begin
         write_msr(`IMMU_MSR_PSR, {30'b0, mode[0], 1'b1});
         for (int i = 32; i < 36; i++)
            send_request(prog_vpn[i]);
      end
      // Lookup in the same cycle as a tag rewrite of its set
      new_vpn = prog_vpn[9] ^ 20'h40000;
      drive_cycle(1'b1, prog_vpn[9], 1'b1, immu_pkg::msr_addr_t'(`IMMU_MSR_TLBL_BASE + 9),
                  {new_vpn, 11'b0, 1'b1});
      send_request(new_vpn);
      send_request(prog_vpn[9]);
      prog_vpn[9] = new_vpn;
      // Random mix, PSR changes under traffic
      for (int i = 0; i < num_random; i++)
      begin
         r = next_rand();
         idx = r[13:8];
         if (r[1:0] == 2'b00)
            vpn = immu_pkg::vpn_t'(r >> 12);
         else
            vpn = prog_vpn[idx];
         if (i % 16 == 15)
            drive_cycle(1'b1, vpn, 1'b1, `IMMU_MSR_PSR, {30'b0, r[21:20]});
         else
            send_request(vpn);
      end
      idle(4);
      if (rsp_checked != req_count)
      begin
         $display("response count mismatch: %0d requests issued, %0d responses checked",
                  req_count, rsp_checked);
         other_errors++;
      end
      $display("value errors: %0d, protocol errors: %0d, other errors: %0d",
               value_errors, protocol_errors, other_errors);
      if (value_errors + protocol_errors + other_errors == 0)
         $display("Result: PASSED");
      else
         $display("Result: FAILED");
      $finish;
   end

   // Watchdog
   initial
   begin
      #(timeout_ns);
      $display("watchdog expired after %0d ns, run did not complete", timeout_ns);
      $display("Result: FAILED");
      $finish;
   end

endmodule

`default_nettype wire

/* ifetch_xlate.f */
+incdir+hw
hw/immu_pkg.sv
hw/tlb_ram.sv
hw/immu_msr_port.sv
hw/immu.sv
hw/ifetch_xlate.sv
testbench/xlate_checker.sv
testbench/tb_ifetch_xlate.sv
